//--- filelist.f
gb_irq_pkg.sv
irq_flags.sv
irq_dispatch.sv
div_timer.sv
joypad_scan.sv
io_bus_decode.sv
gb_irq_top.sv
tb_irq_checker.sv
tb_gb_irq.sv

//--- Makefile
SRCS := $(shell cat filelist.f)

obj_dir/Vtb_gb_irq: $(SRCS) filelist.f
	verilator --binary --timing --assert --top-module tb_gb_irq -f filelist.f -o Vtb_gb_irq

run: obj_dir/Vtb_gb_irq
	@out="$$(./obj_dir/Vtb_gb_irq)"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- tb_gb_irq.sv
module tb_gb_irq;
    timeunit 1ns;
    timeprecision 100ps;
    import gb_irq_pkg::*;

    localparam int          req_timeout  = 200;  // cycles allowed for a request to rise.
    localparam int          ack_timeout  = 20;   // cycles allowed for irq_req to fall.
    localparam int          quiet_cycles = 60;
    localparam logic [31:0] lcg_seed     = 32'd45767;

    localparam logic [2:0] op_write   = 3'd0;
    localparam logic [2:0] op_read    = 3'd1;
    localparam logic [2:0] op_pulse   = 3'd2;  // data bits follow the IF layout.
    localparam logic [2:0] op_buttons = 3'd3;
    localparam logic [2:0] op_serve   = 3'd4;
    localparam logic [2:0] op_quiet   = 3'd5;

    typedef struct packed {
        logic [2:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_val;
        logic [7:0]  mask;
    } step_t;

    logic        clock;
    logic        rst_n;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        wr;
    logic [7:0]  rdata;
    logic        vblank_irq;
    logic        lcdstat_irq;
    logic        serial_irq;
    logic [7:0]  buttons;
    logic        irq_req;
    logic [7:0]  irq_vector;
    logic        irq_ack;
    logic        rd_check;
    logic [7:0]  exp_data;
    logic [7:0]  exp_mask;
    logic        vec_check;
    logic [7:0]  exp_vector;
    logic        quiet_check;
    int          chk_errors;
    int          chk_checks;
    int          timeouts;
    logic [31:0] rng_state;
    step_t       steps[$];

    gb_irq_top #(
        .div_width(16)
    ) i_dut (
        .clock, .rst_n, .addr, .wdata, .wr, .rdata,
        .vblank_irq, .lcdstat_irq, .serial_irq, .buttons,
        .irq_req, .irq_vector, .irq_ack
    );

    tb_irq_checker i_checker (
        .clock, .rst_n, .addr, .rdata, .irq_req, .irq_vector, .irq_ack,
        .rd_check, .exp_data, .exp_mask, .vec_check, .exp_vector, .quiet_check,
        .error_count(chk_errors), .check_count(chk_checks)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_step(input logic [2:0] op, input logic [15:0] a, input logic [7:0] d,
                            input logic [7:0] e, input logic [7:0] m);
        step_t s;
        s.op      = op;
        s.addr    = a;
        s.data    = d;
        s.exp_val = e;
        s.mask    = m;
        steps.push_back(s);
    endtask

    // ####################
    // stimulus table
    // ####################

    task automatic build_table();
        // IE and IF carry three high bits that read back as one.
        add_step(op_read,    addr_ie,   8'h00, 8'he0, 8'hff);
        add_step(op_read,    addr_p1,   8'h00, 8'hff, 8'hff);
        add_step(op_write,   addr_ie,   8'h1f, 8'h00, 8'h00);
        add_step(op_read,    addr_ie,   8'h00, 8'hff, 8'hff);
        add_step(op_write,   addr_tma,  8'h5a, 8'h00, 8'h00);
        add_step(op_read,    addr_tma,  8'h00, 8'h5a, 8'hff);
        add_step(op_write,   addr_tac,  8'h03, 8'h00, 8'h00);
        add_step(op_read,    addr_tac,  8'h00, 8'hfb, 8'hff);
        add_step(op_write,   addr_tac,  8'h00, 8'h00, 8'h00);
        add_step(op_write,   addr_div,  8'h55, 8'h00, 8'h00);
        add_step(op_read,    addr_div,  8'h00, 8'h00, 8'hff);
        add_step(op_write,   addr_p1,   8'h20, 8'h00, 8'h00);
        add_step(op_read,    addr_p1,   8'h00, 8'hef, 8'hff);
        add_step(op_write,   addr_p1,   8'h30, 8'h00, 8'h00);
        add_step(op_read,    addr_p1,   8'h00, 8'hff, 8'hff);
        add_step(op_write,   addr_ie,   8'h00, 8'h00, 8'h00);
        add_step(op_write,   addr_if,   8'h15, 8'h00, 8'h00);
        add_step(op_read,    addr_if,   8'h00, 8'hf5, 8'hff);
        add_step(op_write,   addr_if,   8'h00, 8'h00, 8'h00);
        add_step(op_read,    addr_if,   8'h00, 8'he0, 8'hff);
        add_step(op_read,    16'hff10,  8'h00, 8'hff, 8'hff);
        add_step(op_read,    16'h0000,  8'h00, 8'hff, 8'hff);
        // three sources pulsed at once come out lowest bit first.
        add_step(op_write,   addr_ie,   8'h1f, 8'h00, 8'h00);
        add_step(op_pulse,   16'h0000,  8'h0b, 8'h00, 8'h00);
        add_step(op_serve,   16'h0000,  8'h00, 8'h40, 8'h00);
        add_step(op_serve,   16'h0000,  8'h00, 8'h48, 8'h00);
        add_step(op_serve,   16'h0000,  8'h00, 8'h58, 8'h00);
        add_step(op_read,    addr_if,   8'h00, 8'he0, 8'hff);
        // masking of the serial source.
        add_step(op_write,   addr_ie,   8'h17, 8'h00, 8'h00);
        add_step(op_pulse,   16'h0000,  8'h08, 8'h00, 8'h00);
        add_step(op_quiet,   16'h0000,  8'h00, 8'h00, 8'h00);
        add_step(op_read,    addr_if,   8'h00, 8'he8, 8'hff);
        add_step(op_write,   addr_ie,   8'h1f, 8'h00, 8'h00);
        add_step(op_serve,   16'h0000,  8'h00, 8'h58, 8'h00);
        add_step(op_read,    addr_if,   8'h00, 8'he0, 8'hff);
        // after the overflow TIMA must come back at FEh or above.
        add_step(op_write,   addr_tma,  8'hfe, 8'h00, 8'h00);
        add_step(op_write,   addr_tima, 8'hfe, 8'h00, 8'h00);
        add_step(op_write,   addr_tac,  8'h05, 8'h00, 8'h00);
        add_step(op_serve,   16'h0000,  8'h00, 8'h50, 8'h00);
        add_step(op_write,   addr_tac,  8'h00, 8'h00, 8'h00);
        add_step(op_read,    addr_tima, 8'h00, 8'hfe, 8'hfe);
        // the joypad direction row is selected and the action row is not.
        add_step(op_write,   addr_p1,   8'h20, 8'h00, 8'h00);
        add_step(op_buttons, 16'h0000,  8'hfe, 8'h00, 8'h00);
        add_step(op_serve,   16'h0000,  8'h00, 8'h60, 8'h00);
        add_step(op_read,    addr_p1,   8'h00, 8'hee, 8'hff);
        add_step(op_buttons, 16'h0000,  8'hff, 8'h00, 8'h00);
        add_step(op_buttons, 16'h0000,  8'hef, 8'h00, 8'h00);
        add_step(op_quiet,   16'h0000,  8'h00, 8'h00, 8'h00);
        add_step(op_read,    addr_if,   8'h00, 8'he0, 8'hff);
        add_step(op_buttons, 16'h0000,  8'hff, 8'h00, 8'h00);
        add_step(op_write,   addr_p1,   8'h30, 8'h00, 8'h00);
    endtask

    // models the CPU side of the hand-off with random ack and release delays.
    task automatic serve_irq(input logic [7:0] vec);
        int cnt;
        int delay;
        int hold;
        cnt        = 0;
        exp_vector = vec;
        vec_check  = 1'b1;
        while (!irq_req && cnt < req_timeout) begin
            @(posedge clock);
            cnt++;
        end
        if (!irq_req) begin
            $display("timeout: no interrupt request within %0d cycles", req_timeout);
            timeouts++;
        end else begin
            rng_state = lcg_step(rng_state);
            delay     = int'(rng_state[17:16]) + 1;
            repeat (delay) @(posedge clock);
            #2 irq_ack = 1'b1;
            cnt = 0;
            while (irq_req && cnt < ack_timeout) begin
                @(posedge clock);
                cnt++;
            end
            if (irq_req) begin
                $display("timeout: irq_req stayed high after irq_ack");
                timeouts++;
            end
            // the CPU may keep irq_ack high for a while after irq_req fell.
            rng_state = lcg_step(rng_state);
            hold      = int'(rng_state[17:16]);
            repeat (hold) @(posedge clock);
            #2 irq_ack = 1'b0;
        end
        vec_check = 1'b0;
    endtask

    task automatic apply_step(input step_t s);
        @(posedge clock);
        #2;
        wr       = 1'b0;  // strobes and read checks last one cycle.
        rd_check = 1'b0;
        case (s.op)
            op_write: begin
                addr  = s.addr;
                wdata = s.data;
                wr    = 1'b1;
            end
            op_read: begin
                addr     = s.addr;
                exp_data = s.exp_val;
                exp_mask = s.mask;
                rd_check = 1'b1;
            end
            op_pulse: begin
                vblank_irq  = s.data[irq_bit_vblank];
                lcdstat_irq = s.data[irq_bit_lcdstat];
                serial_irq  = s.data[irq_bit_serial];
                @(posedge clock);
                #2;
                vblank_irq  = 1'b0;
                lcdstat_irq = 1'b0;
                serial_irq  = 1'b0;
            end
            op_buttons: buttons = s.data;
            op_serve:   serve_irq(s.exp_val);
            op_quiet: begin
                quiet_check = 1'b1;
                repeat (quiet_cycles) @(posedge clock);
                #2 quiet_check = 1'b0;
            end
            default: $display("unknown operation %0d in the stimulus table", s.op);
        endcase
    endtask

    initial begin
        rst_n       = 1'b0;
        addr        = 16'h0000;
        wdata       = 8'h00;
        wr          = 1'b0;
        vblank_irq  = 1'b0;
        lcdstat_irq = 1'b0;
        serial_irq  = 1'b0;
        buttons     = 8'hff;  // nothing pressed.
        irq_ack     = 1'b0;
        rd_check    = 1'b0;
        exp_data    = 8'h00;
        exp_mask    = 8'h00;
        vec_check   = 1'b0;
        exp_vector  = 8'h00;
        quiet_check = 1'b0;
        timeouts    = 0;
        rng_state   = lcg_seed;
        build_table();
        repeat (10) @(posedge clock);
        #2 rst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        @(posedge clock);
        #2;
        wr       = 1'b0;
        rd_check = 1'b0;
        repeat (2) @(posedge clock);
        $display("checks %0d, errors %0d, timeouts %0d", chk_checks, chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0 && chk_checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tb_irq_checker.sv
module tb_irq_checker (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [15:0] addr,
    input  logic [7:0]  rdata,
    input  logic        irq_req,
    input  logic [7:0]  irq_vector,
    input  logic        irq_ack,
    input  logic        rd_check,
    input  logic [7:0]  exp_data,
    input  logic [7:0]  exp_mask,
    input  logic        vec_check,
    input  logic [7:0]  exp_vector,
    input  logic        quiet_check,
    output int          error_count,
    output int          check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int   errors = 0;
    int   checks = 0;
    logic prev_req = 1'b0;
    logic prev_ack = 1'b0;
    logic vec_done = 1'b0;       // one vector compare per request.
    logic quiet_flagged = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    // ####################
    // sampling
    // ####################

    // values seen at the edge are the ones that settled during the last cycle.
    always @(posedge clock) begin
        if (!rst_n) begin
            prev_req      = 1'b0;
            prev_ack      = 1'b0;
            vec_done      = 1'b0;
            quiet_flagged = 1'b0;
        end else begin
            if (rd_check) begin
                checks++;
                if ((rdata & exp_mask) !== (exp_data & exp_mask)) begin
                    errors++;
                    $display("FAIL rdata at addr %h: got %h, expected %h (mask %h)",
                             addr, rdata, exp_data, exp_mask);
                end
            end
            if (vec_check && irq_req && !vec_done) begin
                checks++;
                vec_done = 1'b1;
                if (irq_vector !== exp_vector) begin
                    errors++;
                    $display("FAIL irq_vector: got %h, expected %h", irq_vector, exp_vector);
                end
            end
            if (!vec_check) vec_done = 1'b0;
            if (quiet_check && irq_req && !quiet_flagged) begin
                errors++;
                quiet_flagged = 1'b1;
                $display("FAIL irq_req: got %h, expected %h", irq_req, 1'b0);
            end
            if (!quiet_check) quiet_flagged = 1'b0;

            // four-phase rules on the hand-off.
            if (prev_req && !irq_req && !prev_ack) begin
                errors++;
                $display("handshake error: irq_req dropped while irq_ack was low");
            end
            if (!prev_req && irq_req && prev_ack) begin
                errors++;
                $display("handshake error: new irq_req rose before irq_ack fell");
            end
            prev_req = irq_req;
            prev_ack = irq_ack;
        end
    end

endmodule

//--- gb_irq_top.sv
module gb_irq_top #(
    parameter int div_width = 16
) (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [15:0] addr,
    input  logic [7:0]  wdata,
    input  logic        wr,
    output logic [7:0]  rdata,
    input  logic        vblank_irq,
    input  logic        lcdstat_irq,
    input  logic        serial_irq,
    input  logic [7:0]  buttons,
    output logic        irq_req,
    output logic [7:0]  irq_vector,
    input  logic        irq_ack
);
    import gb_irq_pkg::*;

    logic                 wr_p1;
    logic                 wr_div;
    logic                 wr_tima;
    logic                 wr_tma;
    logic                 wr_tac;
    logic                 wr_if;
    logic                 wr_ie;
    logic [7:0]           p1_value;
    logic [7:0]           div_value;
    logic [7:0]           tima_value;
    logic [7:0]           tma_value;
    logic [7:0]           tac_value;
    irq_byte_u            if_value;
    irq_byte_u            ie_value;
    logic                 timer_irq;
    logic                 joypad_irq;
    logic                 clear_strobe;
    logic [irq_idx_w-1:0] clear_index;

    io_bus_decode i_decode (
        .addr, .wdata, .wr,
        .p1_value, .div_value, .tima_value, .tma_value, .tac_value,
        .if_value, .ie_value,
        .rdata,
        .wr_p1, .wr_div, .wr_tima, .wr_tma, .wr_tac, .wr_if, .wr_ie
    );

    irq_flags i_flags (
        .clock, .rst_n, .wdata, .wr_if, .wr_ie,
        .vblank_irq, .lcdstat_irq, .timer_irq, .serial_irq, .joypad_irq,
        .clear_strobe, .clear_index,
        .if_value, .ie_value
    );

    irq_dispatch i_dispatch (
        .clock, .rst_n, .if_value, .ie_value, .irq_ack,
        .irq_req, .irq_vector, .clear_strobe, .clear_index
    );

    div_timer #(
        .div_width(div_width)
    ) i_timer (
        .clock, .rst_n, .wdata, .wr_div, .wr_tima, .wr_tma, .wr_tac,
        .div_value, .tima_value, .tma_value, .tac_value, .timer_irq
    );

    joypad_scan i_joypad (
        .clock, .rst_n, .wdata, .wr_p1, .buttons,
        .p1_value, .joypad_irq
    );

endmodule

//--- io_bus_decode.sv
module io_bus_decode (
    input  logic [15:0]           addr,
    input  logic [7:0]            wdata,
    input  logic                  wr,
    input  logic [7:0]            p1_value,
    input  logic [7:0]            div_value,
    input  logic [7:0]            tima_value,
    input  logic [7:0]            tma_value,
    input  logic [7:0]            tac_value,
    input  gb_irq_pkg::irq_byte_u if_value,
    input  gb_irq_pkg::irq_byte_u ie_value,
    output logic [7:0]            rdata,
    output logic                  wr_p1,
    output logic                  wr_div,
    output logic                  wr_tima,
    output logic                  wr_tma,
    output logic                  wr_tac,
    output logic                  wr_if,
    output logic                  wr_ie
);
    import gb_irq_pkg::*;

    // ####################
    // write strobes
    // ####################

    assign wr_p1   = wr && (addr == addr_p1);
    assign wr_div  = wr && (addr == addr_div);
    assign wr_tima = wr && (addr == addr_tima);
    assign wr_tma  = wr && (addr == addr_tma);
    assign wr_tac  = wr && (addr == addr_tac);
    assign wr_if   = wr && (addr == addr_if);
    assign wr_ie   = wr && (addr == addr_ie);

    // read data follows the address without a clock.
    always_comb begin
        case (addr)
            addr_p1:   rdata = p1_value;
            addr_div:  rdata = div_value;
            addr_tima: rdata = tima_value;
            addr_tma:  rdata = tma_value;
            addr_tac:  rdata = tac_value;
            addr_if:   rdata = if_value.raw;
            addr_ie:   rdata = ie_value.raw;
            default:   rdata = 8'hff;  // open bus.
        endcase
    end

    // the register map must never let one write reach two owners.
    always_comb begin
        a_one_strobe: assert ($onehot0({wr_p1, wr_div, wr_tima, wr_tma,
                                        wr_tac, wr_if, wr_ie}))
            else $error("several write strobes for address %h", addr);
    end

endmodule

//--- joypad_scan.sv
module joypad_scan (
    input  logic       clock,
    input  logic       rst_n,
    input  logic [7:0] wdata,
    input  logic       wr_p1,
    input  logic [7:0] buttons,
    output logic [7:0] p1_value,
    output logic       joypad_irq
);

    logic [1:0] sel_q;   // bit 0 picks the directions, bit 1 the actions.
    logic [3:0] rows;
    logic [3:0] rows_q;
    logic       irq_q;

    // a low select bit lets its row through, pressed keys pull lines low.
    assign rows = (sel_q[0] ? 4'hf : buttons[3:0]) &
                  (sel_q[1] ? 4'hf : buttons[7:4]);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sel_q  <= 2'b11;
            rows_q <= 4'hf;
            irq_q  <= 1'b0;
        end else begin
            if (wr_p1) begin
                sel_q <= wdata[5:4];
            end
            rows_q <= rows;
            irq_q  <= |(rows_q & ~rows);  // any line falling from high to low.
        end
    end

    assign p1_value   = {2'b11, sel_q, rows};
    assign joypad_irq = irq_q;

endmodule

//--- div_timer.sv
module div_timer #(
    parameter int div_width = 16
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic [7:0] wdata,
    input  logic       wr_div,
    input  logic       wr_tima,
    input  logic       wr_tma,
    input  logic       wr_tac,
    output logic [7:0] div_value,
    output logic [7:0] tima_value,
    output logic [7:0] tma_value,
    output logic [7:0] tac_value,
    output logic       timer_irq
);

    logic [div_width-1:0] div_q;
    logic [7:0]           tima_q;
    logic [7:0]           tma_q;
    logic [2:0]           tac_q;
    logic                 tap_now;
    logic                 tap_q;
    logic                 tick;
    logic                 irq_q;

    // ####################
    // divider
    // ####################

    always_ff @(posedge clock) begin
        if (!rst_n || wr_div) begin
            div_q <= '0;  // any write to DIV restarts the count.
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign div_value = div_q[div_width-1 -: 8];

    // TAC bits 1:0 choose how fast TIMA runs.
    always_comb begin
        case (tac_q[1:0])
            2'b00:   tap_now = div_q[9];
            2'b01:   tap_now = div_q[3];
            2'b10:   tap_now = div_q[5];
            default: tap_now = div_q[7];
        endcase
    end

    // a TAC write forgets the old tap so a select change cannot fake an edge.
    always_ff @(posedge clock) begin
        if (!rst_n || wr_tac) begin
            tap_q <= 1'b0;
        end else begin
            tap_q <= tap_now;
        end
    end

    assign tick = tac_q[2] & tap_q & ~tap_now;  // falling edge of the tap.

    // ####################
    // timer registers
    // ####################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            tima_q <= 8'h00;
            tma_q  <= 8'h00;
            tac_q  <= 3'b000;
            irq_q  <= 1'b0;
        end else begin
            irq_q <= 1'b0;
            if (wr_tima) begin
                tima_q <= wdata;  // the CPU wins over a tick.
            end else if (tick) begin
                if (tima_q == 8'hff) begin
                    tima_q <= tma_q;
                    irq_q  <= 1'b1;
                end else begin
                    tima_q <= tima_q + 8'd1;
                end
            end
            if (wr_tma) tma_q <= wdata;
            if (wr_tac) tac_q <= wdata[2:0];
        end
    end

    assign tima_value = tima_q;
    assign tma_value  = tma_q;
    assign tac_value  = {5'b11111, tac_q};  // upper bits are not stored.
    assign timer_irq  = irq_q;

endmodule

//--- irq_dispatch.sv
module irq_dispatch (
    input  logic                                clock,
    input  logic                                rst_n,
    input  gb_irq_pkg::irq_byte_u               if_value,
    input  gb_irq_pkg::irq_byte_u               ie_value,
    input  logic                                irq_ack,
    output logic                                irq_req,
    output logic [7:0]                          irq_vector,
    output logic                                clear_strobe,
    output logic [gb_irq_pkg::irq_idx_w-1:0]    clear_index
);
    import gb_irq_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_req  = 2'd1;  // irq_req is high in this state.
    localparam logic [1:0] st_wait = 2'd2;  // waiting for irq_ack to drop.

    logic [1:0]           state;
    logic [num_irq-1:0]   pending;
    logic [irq_idx_w-1:0] pick;
    logic                 clear_q;

    // picks the lowest set bit, which is the highest priority source.
    function automatic logic [irq_idx_w-1:0] lowest_index(input logic [num_irq-1:0] vec);
        logic [irq_idx_w-1:0] idx;
        idx = '0;
        for (int i = num_irq - 1; i >= 0; i--) begin
            if (vec[i]) idx = irq_idx_w'(i);
        end
        return idx;
    endfunction

    assign pending = {if_value.bits.joypad  & ie_value.bits.joypad,
                      if_value.bits.serial  & ie_value.bits.serial,
                      if_value.bits.timer   & ie_value.bits.timer,
                      if_value.bits.lcdstat & ie_value.bits.lcdstat,
                      if_value.bits.vblank  & ie_value.bits.vblank};
    assign pick = lowest_index(pending);

    // ####################
    // handshake FSM
    // ####################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= st_idle;
            clear_q <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            case (state)
                st_idle: if (|pending) state <= st_req;
                st_req: begin
                    if (irq_ack) begin
                        state   <= st_wait;
                        clear_q <= 1'b1;  // drop the served flag once.
                    end
                end
                st_wait: if (!irq_ack) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // index and vector are frozen on entry to the request state.
    always_ff @(posedge clock) begin
        if (state == st_idle && |pending) begin
            clear_index <= pick;
            irq_vector  <= vector_base + {2'b00, pick, 3'b000};
        end
    end

    assign irq_req      = (state == st_req);
    assign clear_strobe = clear_q;

    // the CPU must see one vector for the whole request.
    a_vector_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        (irq_req && $past(irq_req)) |-> $stable(irq_vector)
    ) else $error("irq_vector changed during a request");

    a_req_falls_on_ack: assert property (
        @(posedge clock) disable iff (!rst_n)
        $fell(irq_req) |-> $past(irq_ack)
    ) else $error("irq_req dropped without irq_ack");

endmodule

//--- irq_flags.sv
module irq_flags (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [7:0]                          wdata,
    input  logic                                wr_if,
    input  logic                                wr_ie,
    input  logic                                vblank_irq,
    input  logic                                lcdstat_irq,
    input  logic                                timer_irq,
    input  logic                                serial_irq,
    input  logic                                joypad_irq,
    input  logic                                clear_strobe,
    input  logic [gb_irq_pkg::irq_idx_w-1:0]    clear_index,
    output gb_irq_pkg::irq_byte_u               if_value,
    output gb_irq_pkg::irq_byte_u               ie_value
);
    import gb_irq_pkg::*;

    irq_byte_u if_q;
    irq_byte_u ie_q;
    irq_byte_u if_d;

    // ####################
    // next IF value
    // ####################

    // a CPU write replaces the flags, a service clear drops one of them.
    // source pulses are merged last so they win over both.
    always_comb begin
        if_d = if_q;
        if (wr_if) begin
            if_d.raw = {3'b111, wdata[num_irq-1:0]};
        end else if (clear_strobe) begin
            if_d.raw[clear_index] = 1'b0;
        end
        if_d.raw[irq_bit_vblank]  = if_d.raw[irq_bit_vblank]  | vblank_irq;
        if_d.raw[irq_bit_lcdstat] = if_d.raw[irq_bit_lcdstat] | lcdstat_irq;
        if_d.raw[irq_bit_timer]   = if_d.raw[irq_bit_timer]   | timer_irq;
        if_d.raw[irq_bit_serial]  = if_d.raw[irq_bit_serial]  | serial_irq;
        if_d.raw[irq_bit_joypad]  = if_d.raw[irq_bit_joypad]  | joypad_irq;
    end

    // ####################
    // registers
    // ####################

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            if_q.raw <= 8'he0;  // flags clear, unused bits read as one.
            ie_q.raw <= 8'he0;
        end else begin
            if_q <= if_d;
            if (wr_ie) begin
                ie_q.raw <= {3'b111, wdata[num_irq-1:0]};
            end
        end
    end

    assign if_value = if_q;
    assign ie_value = ie_q;

    // the dispatcher may only ask to clear a source that exists.
    a_clear_index_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        clear_strobe |-> (clear_index < num_irq)
    ) else $error("clear_index %0d out of range", clear_index);

endmodule

//--- gb_irq_pkg.sv
package gb_irq_pkg;

    // ####################
    // interrupt sources
    // ####################

    // bit positions inside IF and IE, lowest bit has the highest priority.
    localparam int irq_bit_vblank  = 0;
    localparam int irq_bit_lcdstat = 1;
    localparam int irq_bit_timer   = 2;
    localparam int irq_bit_serial  = 3;
    localparam int irq_bit_joypad  = 4;

    localparam int num_irq   = 5;
    localparam int irq_idx_w = $clog2(num_irq);  // width of a source index.

    // ####################
    // register map
    // ####################

    localparam logic [15:0] addr_p1   = 16'hff00;  // joypad select and rows.
    localparam logic [15:0] addr_div  = 16'hff04;
    localparam logic [15:0] addr_tima = 16'hff05;
    localparam logic [15:0] addr_tma  = 16'hff06;
    localparam logic [15:0] addr_tac  = 16'hff07;
    localparam logic [15:0] addr_if   = 16'hff0f;
    localparam logic [15:0] addr_ie   = 16'hffff;

    // source n jumps to vector_base + 8 * n.
    localparam logic [7:0] vector_base = 8'h40;

    // ####################
    // flag byte
    // ####################

    // named view of an IF or IE byte, the top three bits carry no flag.
    typedef struct packed {
        logic [2:0] unused;
        logic       joypad;
        logic       serial;
        logic       timer;
        logic       lcdstat;
        logic       vblank;
    } irq_bits_t;

    // the bus sees the raw byte, the interrupt logic the named flags.
    typedef union packed {
        logic [7:0] raw;
        irq_bits_t  bits;
    } irq_byte_u;

endpackage
